/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_instr_ctl
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+include
logic/ctl_pkg.sv
logic/branch_resolver.sv
logic/ctrl_decoder.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/instr_ctl.sv
testbench/tb_instr_ctl.sv

/* include/ctl_settings.svh */
`ifndef CTL_SETTINGS_SVH
`define CTL_SETTINGS_SVH

// Instruction word width
`define CTL_XLEN 32

// Opcode field, instr[6:0]
`define CTL_OPCODE_W 7

// Minor opcode field, instr[14:12]
`define CTL_FUNCT3_W 3

// ALU operation select
`define CTL_ALU_SEL_W 4

// Immediate generator format select
`define CTL_IMM_SEL_W 4

// Register file write-back source select
`define CTL_WB_SEL_W 2

`endif

/* logic/branch_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module branch_resolver (
    input  wire [`CTL_FUNCT3_W-1:0] funct3,
    input  wire                     br_eq,
    input  wire                     br_lt,
    output logic                    br_un,
    output logic                    take
);

    logic cond;

    // Unsigned compare for BLTU and BGEU
    assign br_un = funct3[2] & funct3[1];

    // funct3[2] picks less-than over equal
    always_comb begin
        case (funct3[2])
            1'b0:    cond = br_eq;
            default: cond = br_lt;
        endcase
    end

    // Odd funct3 is the negated form (BNE, BGE, BGEU)
    assign take = cond ^ funct3[0];

endmodule

`default_nettype wire

/* logic/ctl_pkg.sv */
`default_nettype none

`include "ctl_settings.svh"

package ctl_pkg;

    // RV32I major opcodes
    typedef enum logic [`CTL_OPCODE_W-1:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // ALU encodings as the datapath ALU expects them
    typedef enum logic [`CTL_ALU_SEL_W-1:0] {
        ALU_AND    = 0,
        ALU_OR     = 1,
        ALU_XOR    = 2,
        ALU_ADD    = 3,
        ALU_SUB    = 4,
        ALU_PASS_B = 6,
        ALU_SLL    = 7,
        ALU_SRL    = 8,
        ALU_SRA    = 10,
        ALU_SLTU   = 11,
        ALU_SLT    = 12
    } alu_op_e;

    typedef enum logic [`CTL_IMM_SEL_W-1:0] {
        IMM_R = 0,
        IMM_I = 1,
        IMM_S = 2,
        IMM_B = 3,
        IMM_U = 4,
        IMM_J = 5
    } imm_sel_e;

    typedef enum logic [`CTL_WB_SEL_W-1:0] {
        WB_MEM = 0,
        WB_ALU = 1,
        WB_PC4 = 2
    } wb_sel_e;

    // Datapath control bundle
    typedef struct packed {
        logic     a_sel;    // 0 rs1, 1 PC
        logic     b_sel;    // 0 rs2, 1 immediate
        alu_op_e  alu_sel;
        logic     mem_wr;
        logic     reg_wen;
        logic     br_un;
        logic     pc_sel;
        wb_sel_e  wb_sel;
    } ctrl_t;

endpackage

`default_nettype wire

/* logic/ctrl_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module ctrl_decoder (
    input  wire [`CTL_XLEN-1:0] instr,
    output ctl_pkg::ctrl_t      ctrl,
    output logic                is_branch
);

    logic [`CTL_OPCODE_W-1:0] opcode;
    logic [`CTL_FUNCT3_W-1:0] funct3;
    logic [6:0]               funct7;
    logic                     funct7_ok;

    assign opcode = instr[`CTL_OPCODE_W-1:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // OP accepts only the base and the alternate encoding (bit 30)
    assign funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

    // ALU operation shared by OP-IMM and OP
    function automatic ctl_pkg::alu_op_e alu_for(
        input logic [`CTL_FUNCT3_W-1:0] f3,
        input logic                     sub,
        input logic                     sra
    );
        ctl_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = sub ? ctl_pkg::ALU_SUB : ctl_pkg::ALU_ADD;
            3'b001:  op = ctl_pkg::ALU_SLL;
            3'b010:  op = ctl_pkg::ALU_SLT;
            3'b011:  op = ctl_pkg::ALU_SLTU;
            3'b100:  op = ctl_pkg::ALU_XOR;
            3'b101:  op = sra ? ctl_pkg::ALU_SRA : ctl_pkg::ALU_SRL;
            3'b110:  op = ctl_pkg::ALU_OR;
            default: op = ctl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl      = '0;
        is_branch = 1'b0;
        case (opcode)
            ctl_pkg::OPC_LUI: begin
                ctrl.b_sel   = 1'b1;
                ctrl.alu_sel = ctl_pkg::ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = ctl_pkg::WB_ALU;
            end
            ctl_pkg::OPC_AUIPC: begin
                ctrl.a_sel   = 1'b1;
                ctrl.b_sel   = 1'b1;
                ctrl.alu_sel = ctl_pkg::ALU_ADD;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = ctl_pkg::WB_ALU;
            end
            ctl_pkg::OPC_JAL: begin
                ctrl.a_sel   = 1'b1;
                ctrl.b_sel   = 1'b1;
                ctrl.alu_sel = ctl_pkg::ALU_ADD;
                ctrl.reg_wen = 1'b1;
                ctrl.pc_sel  = 1'b1;
                ctrl.wb_sel  = ctl_pkg::WB_PC4;
            end
            ctl_pkg::OPC_JALR: begin
                // Target is rs1 plus immediate
                ctrl.b_sel   = 1'b1;
                ctrl.alu_sel = ctl_pkg::ALU_ADD;
                ctrl.reg_wen = 1'b1;
                ctrl.pc_sel  = 1'b1;
                ctrl.wb_sel  = ctl_pkg::WB_PC4;
            end
            ctl_pkg::OPC_BRANCH: begin
                // pc_sel and br_un are filled in by the branch resolver
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    ctrl.a_sel   = 1'b1;
                    ctrl.b_sel   = 1'b1;
                    ctrl.alu_sel = ctl_pkg::ALU_ADD;
                    is_branch    = 1'b1;
                end
            end
            ctl_pkg::OPC_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                    ctrl.b_sel   = 1'b1;
                    ctrl.alu_sel = ctl_pkg::ALU_ADD;
                    ctrl.reg_wen = 1'b1;
                    ctrl.wb_sel  = ctl_pkg::WB_MEM;
                end
            end
            ctl_pkg::OPC_STORE: begin
                // SB, SH and SW only
                if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
                    ctrl.b_sel   = 1'b1;
                    ctrl.alu_sel = ctl_pkg::ALU_ADD;
                    ctrl.mem_wr  = 1'b1;
                end
            end
            ctl_pkg::OPC_OP_IMM: begin
                // No SUBI, so bit 30 only picks SRAI
                ctrl.b_sel   = 1'b1;
                ctrl.alu_sel = alu_for(funct3, 1'b0, instr[30]);
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = ctl_pkg::WB_ALU;
            end
            ctl_pkg::OPC_OP: begin
                if (funct7_ok) begin
                    ctrl.alu_sel = alu_for(funct3, instr[30], instr[30]);
                    ctrl.reg_wen = 1'b1;
                    ctrl.wb_sel  = ctl_pkg::WB_ALU;
                end
            end
            default: begin
                // FENCE, ECALL, EBREAK and unknown opcodes need nothing from the datapath
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module decode_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`CTL_XLEN-1:0]     instruction,
    output logic [`CTL_XLEN-1:0]    instr_de,
    output ctl_pkg::imm_sel_e       imm_sel
);

    logic [`CTL_OPCODE_W-1:0] opcode;
    ctl_pkg::imm_sel_e        imm_sel_next;

    assign opcode = instruction[`CTL_OPCODE_W-1:0];

    // Immediate format depends on the opcode alone
    always_comb begin
        case (opcode)
            ctl_pkg::OPC_JALR,
            ctl_pkg::OPC_LOAD,
            ctl_pkg::OPC_OP_IMM: begin
                imm_sel_next = ctl_pkg::IMM_I;
            end
            ctl_pkg::OPC_LUI,
            ctl_pkg::OPC_AUIPC: begin
                imm_sel_next = ctl_pkg::IMM_U;
            end
            ctl_pkg::OPC_JAL: begin
                imm_sel_next = ctl_pkg::IMM_J;
            end
            ctl_pkg::OPC_BRANCH: begin
                imm_sel_next = ctl_pkg::IMM_B;
            end
            ctl_pkg::OPC_STORE: begin
                imm_sel_next = ctl_pkg::IMM_S;
            end
            default: begin
                imm_sel_next = ctl_pkg::IMM_R;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_de <= '0;
            imm_sel  <= ctl_pkg::IMM_R;
        end else begin
            instr_de <= instruction;
            imm_sel  <= imm_sel_next;
        end
    end

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module exec_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [`CTL_XLEN-1:0] instr_de,
    input  wire                 br_eq,
    input  wire                 br_lt,
    output ctl_pkg::ctrl_t      ctrl
);

    ctl_pkg::ctrl_t dec_ctrl;
    ctl_pkg::ctrl_t ctrl_next;
    logic           is_branch;
    logic           res_br_un;
    logic           res_take;

    ctrl_decoder u_ctrl_decoder (
        .instr     (instr_de),
        .ctrl      (dec_ctrl),
        .is_branch (is_branch)
    );

    branch_resolver u_branch_resolver (
        .funct3 (instr_de[14:12]),
        .br_eq  (br_eq),
        .br_lt  (br_lt),
        .br_un  (res_br_un),
        .take   (res_take)
    );

    // Branch outcome overrides the static decode
    always_comb begin
        ctrl_next = dec_ctrl;
        if (is_branch) begin
            ctrl_next.pc_sel = res_take;
            ctrl_next.br_un  = res_br_un;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

/* logic/instr_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module instr_ctl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [`CTL_XLEN-1:0] instruction,
    input  wire                 br_eq,
    input  wire                 br_lt,
    output ctl_pkg::imm_sel_e   imm_sel,
    output ctl_pkg::ctrl_t      ctrl
);

    // Instruction held in the decode register
    logic [`CTL_XLEN-1:0] instr_de;

    // Stage 1, immediate format
    decode_stage u_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .instr_de    (instr_de),
        .imm_sel     (imm_sel)
    );

    // Stage 2, control bundle with the branch decision
    exec_stage u_exec_stage (
        .clk      (clk),
        .rst      (rst),
        .instr_de (instr_de),
        .br_eq    (br_eq),
        .br_lt    (br_lt),
        .ctrl     (ctrl)
    );

endmodule

`default_nettype wire

/* include/tb_ctl_ref.svh */
`ifndef TB_CTL_REF_SVH
`define TB_CTL_REF_SVH

// Immediate format, decided by the opcode bits alone
function automatic ctl_pkg::imm_sel_e imm_sel_for(input logic [31:0] w);
    ctl_pkg::imm_sel_e sel;
    case (w[6:0])
        7'b1100111, 7'b0000011, 7'b0010011: sel = ctl_pkg::IMM_I;
        7'b0110111, 7'b0010111:             sel = ctl_pkg::IMM_U;
        7'b1101111:                         sel = ctl_pkg::IMM_J;
        7'b1100011:                         sel = ctl_pkg::IMM_B;
        7'b0100011:                         sel = ctl_pkg::IMM_S;
        default:                            sel = ctl_pkg::IMM_R;
    endcase
    return sel;
endfunction

// Register and immediate arithmetic, SUB only exists with two registers
function automatic ctl_pkg::alu_op_e alu_operation(
    input logic [2:0] f3,
    input logic       bit30,
    input logic       two_regs
);
    ctl_pkg::alu_op_e op;
    case (f3)
        3'b000:  op = (two_regs && bit30) ? ctl_pkg::ALU_SUB : ctl_pkg::ALU_ADD;
        3'b001:  op = ctl_pkg::ALU_SLL;
        3'b010:  op = ctl_pkg::ALU_SLT;
        3'b011:  op = ctl_pkg::ALU_SLTU;
        3'b100:  op = ctl_pkg::ALU_XOR;
        3'b101:  op = bit30 ? ctl_pkg::ALU_SRA : ctl_pkg::ALU_SRL;
        3'b110:  op = ctl_pkg::ALU_OR;
        default: op = ctl_pkg::ALU_AND;
    endcase
    return op;
endfunction

// Expected bundle for a word in the decode register and the flags of that cycle
function automatic ctl_pkg::ctrl_t bundle_for(input logic [31:0] w, input logic eq, input logic lt);
    ctl_pkg::ctrl_t c;
    logic [2:0]     f3;
    logic [6:0]     f7;
    c  = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
        7'b0110111: begin
            c.b_sel   = 1'b1;
            c.alu_sel = ctl_pkg::ALU_PASS_B;
            c.reg_wen = 1'b1;
            c.wb_sel  = ctl_pkg::WB_ALU;
        end
        7'b0010111: begin
            c.a_sel   = 1'b1;
            c.b_sel   = 1'b1;
            c.alu_sel = ctl_pkg::ALU_ADD;
            c.reg_wen = 1'b1;
            c.wb_sel  = ctl_pkg::WB_ALU;
        end
        7'b1101111, 7'b1100111: begin
            // JAL adds to the PC, JALR to rs1
            c.a_sel   = (w[6:0] == 7'b1101111);
            c.b_sel   = 1'b1;
            c.alu_sel = ctl_pkg::ALU_ADD;
            c.reg_wen = 1'b1;
            c.pc_sel  = 1'b1;
            c.wb_sel  = ctl_pkg::WB_PC4;
        end
        7'b1100011: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                c.a_sel   = 1'b1;
                c.b_sel   = 1'b1;
                c.alu_sel = ctl_pkg::ALU_ADD;
                c.br_un   = (f3 == 3'b110 || f3 == 3'b111);
                case (f3)
                    3'b000:  c.pc_sel = eq;
                    3'b001:  c.pc_sel = ~eq;
                    3'b100:  c.pc_sel = lt;
                    3'b110:  c.pc_sel = lt;
                    default: c.pc_sel = ~lt;
                endcase
            end
        end
        7'b0000011: begin
            // LB LH LW LBU LHU
            case (f3)
                3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
                    c.b_sel   = 1'b1;
                    c.alu_sel = ctl_pkg::ALU_ADD;
                    c.reg_wen = 1'b1;
                    c.wb_sel  = ctl_pkg::WB_MEM;
                end
                default: c = '0;
            endcase
        end
        7'b0100011: begin
            if (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b010) begin
                c.b_sel   = 1'b1;
                c.alu_sel = ctl_pkg::ALU_ADD;
                c.mem_wr  = 1'b1;
            end
        end
        7'b0010011: begin
            c.b_sel   = 1'b1;
            c.alu_sel = alu_operation(f3, w[30], 1'b0);
            c.reg_wen = 1'b1;
            c.wb_sel  = ctl_pkg::WB_ALU;
        end
        7'b0110011: begin
            if (f7 == 7'b0000000 || f7 == 7'b0100000) begin
                c.alu_sel = alu_operation(f3, w[30], 1'b1);
                c.reg_wen = 1'b1;
                c.wb_sel  = ctl_pkg::WB_ALU;
            end
        end
        default: c = '0;
    endcase
    return c;
endfunction

`endif

/* testbench/tb_instr_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module tb_instr_ctl;

    localparam int NUM_SWEEP   = 37;
    localparam int NUM_ILLEGAL = 15;
    localparam int NUM_RANDOM  = 2000;
    // Sweep position of BEQ with the other five branches right after it
    localparam int BRANCH_BASE = 4;
    // Reset, release cycle, sweep, branch pairs, illegal words and drain
    localparam int DIRECTED_CYCLES = 11 + NUM_SWEEP + 6 * 4 * 2 + NUM_ILLEGAL + 3;
    localparam int WATCHDOG_CYCLES = DIRECTED_CYCLES + NUM_RANDOM + 50;

    logic                 clk;
    logic                 rst;
    logic [`CTL_XLEN-1:0] instruction;
    logic                 br_eq;
    logic                 br_lt;
    ctl_pkg::imm_sel_e    imm_sel;
    ctl_pkg::ctrl_t       ctrl;

    integer      seed;
    int          checks_done;
    logic [31:0] sweep_words[$];
    logic [31:0] illegal_words[$];

    instr_ctl u_dut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .imm_sel     (imm_sel),
        .ctrl        (ctrl)
    );

    `include "tb_ctl_ref.svh"

    always #5 clk = ~clk;

    // Register fields stay fixed since only opcode, funct3 and funct7 matter
    function automatic logic [31:0] make_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] opc);
        return {f7, 5'd7, 5'd6, f3, 5'd5, opc};
    endfunction

    task automatic fill_word_lists();
        int f;
        sweep_words.push_back(make_word(7'h12, 3'd5, 7'b0110111));
        sweep_words.push_back(make_word(7'h40, 3'd1, 7'b0010111));
        sweep_words.push_back(make_word(7'h7f, 3'd7, 7'b1101111));
        sweep_words.push_back(make_word(7'h00, 3'd0, 7'b1100111));
        for (f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                sweep_words.push_back(make_word(7'h00, 3'(f), 7'b1100011));
            end
        end
        for (f = 0; f < 6; f++) begin
            if (f != 3) begin
                sweep_words.push_back(make_word(7'h00, 3'(f), 7'b0000011));
            end
        end
        for (f = 0; f < 3; f++) begin
            sweep_words.push_back(make_word(7'h00, 3'(f), 7'b0100011));
        end
        for (f = 0; f < 8; f++) begin
            sweep_words.push_back(make_word(7'h00, 3'(f), 7'b0010011));
            sweep_words.push_back(make_word(7'h00, 3'(f), 7'b0110011));
        end
        // SRAI, SUB and SRA
        sweep_words.push_back(make_word(7'h20, 3'd5, 7'b0010011));
        sweep_words.push_back(make_word(7'h20, 3'd0, 7'b0110011));
        sweep_words.push_back(make_word(7'h20, 3'd5, 7'b0110011));
        // FENCE, ECALL, EBREAK and then unknown opcodes
        illegal_words.push_back(32'h0ff0_000f);
        illegal_words.push_back(32'h0000_0073);
        illegal_words.push_back(32'h0010_0073);
        illegal_words.push_back(32'h0000_0000);
        illegal_words.push_back(make_word(7'h00, 3'd0, 7'b1111111));
        illegal_words.push_back(make_word(7'h00, 3'd0, 7'b1010111));
        // Unused funct3 and funct7 values
        illegal_words.push_back(make_word(7'h00, 3'd2, 7'b1100011));
        illegal_words.push_back(make_word(7'h00, 3'd3, 7'b1100011));
        illegal_words.push_back(make_word(7'h00, 3'd3, 7'b0000011));
        illegal_words.push_back(make_word(7'h00, 3'd6, 7'b0000011));
        illegal_words.push_back(make_word(7'h00, 3'd7, 7'b0000011));
        illegal_words.push_back(make_word(7'h00, 3'd3, 7'b0100011));
        illegal_words.push_back(make_word(7'h00, 3'd4, 7'b0100011));
        illegal_words.push_back(make_word(7'h01, 3'd0, 7'b0110011));
        illegal_words.push_back(make_word(7'h21, 3'd5, 7'b0110011));
    endtask

    task automatic drive_cycle(input logic [31:0] w, input logic eq, input logic lt);
        @(posedge clk);
        #1;
        instruction = w;
        br_eq       = eq;
        br_lt       = lt;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, expected);
        $display("*** TEST FAILED ***");
        $fatal(1, "output check failed");
    endtask

    initial begin
        int          i;
        int          j;
        int          idx;
        logic [31:0] r;
        logic [31:0] w;
        seed = 32'h6249_9f6b;
        clk  = 1'b0;
        rst  = 1'b1;
        // A live JAL during reset must not reach the outputs
        instruction = make_word(7'h00, 3'd0, 7'b1101111);
        br_eq       = 1'b1;
        br_lt       = 1'b1;
        fill_word_lists();
        repeat (10) @(posedge clk);
        #1;
        rst         = 1'b0;
        instruction = '0;
        br_eq       = 1'b0;
        br_lt       = 1'b0;
        // Every kept instruction back to back
        for (i = 0; i < NUM_SWEEP; i++) begin
            r = $random(seed);
            drive_cycle(sweep_words[i], r[0], r[1]);
        end
        // Flags belong to the cycle after the branch
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 4; j++) begin
                drive_cycle(sweep_words[BRANCH_BASE + i], 1'b0, 1'b0);
                drive_cycle(sweep_words[0], j[1], j[0]);
            end
        end
        for (i = 0; i < NUM_ILLEGAL; i++) begin
            r = $random(seed);
            drive_cycle(illegal_words[i], r[0], r[1]);
        end
        // Mix of raw words, random bodies on kept opcodes and sweep entries
        for (i = 0; i < NUM_RANDOM; i++) begin
            r   = $random(seed);
            w   = $random(seed);
            idx = int'(r[15:8]) % NUM_SWEEP;
            if (r[3:2] == 2'b01) begin
                w[6:0] = sweep_words[idx][6:0];
            end else if (r[3]) begin
                w = sweep_words[idx];
            end
            drive_cycle(w, r[0], r[1]);
        end
        drive_cycle('0, 1'b0, 1'b0);
        drive_cycle('0, 1'b0, 1'b0);
        @(posedge clk);
        #1;
        if (checks_done == 0) begin
            $display("the scoreboard never compared an output");
            $display("*** TEST FAILED ***");
            $fatal(1, "no checks ran");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Inputs settle 1 ns after the edge and outputs are checked 1 ns before the next
    initial begin
        logic [31:0]       p_instr;
        logic              p_eq;
        logic              p_lt;
        logic              p_rst;
        logic              have_pending;
        logic [31:0]       model_de;
        ctl_pkg::imm_sel_e exp_imm;
        ctl_pkg::ctrl_t    exp_ctrl;
        have_pending = 1'b0;
        p_instr      = '0;
        p_eq         = 1'b0;
        p_lt         = 1'b0;
        p_rst        = 1'b1;
        model_de     = '0;
        checks_done  = 0;
        forever begin
            @(posedge clk);
            #9;
            if (have_pending) begin
                if (p_rst) begin
                    exp_imm  = ctl_pkg::IMM_R;
                    exp_ctrl = '0;
                    model_de = '0;
                end else begin
                    exp_imm  = imm_sel_for(p_instr);
                    exp_ctrl = bundle_for(model_de, p_eq, p_lt);
                    model_de = p_instr;
                end
                assert (imm_sel === exp_imm)
                    else report_mismatch("imm_sel", 32'(imm_sel), 32'(exp_imm));
                assert (ctrl === exp_ctrl)
                    else report_mismatch("ctrl", 32'(ctrl), 32'(exp_ctrl));
                checks_done++;
            end
            // Values the next edge will sample
            p_instr      = instruction;
            p_eq         = br_eq;
            p_lt         = br_lt;
            p_rst        = rst;
            have_pending = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run was still going after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
